// File: design/ahb_pkg.sv
package ahb_pkg;

	// ----------------------------------------
	// Bus field types
	// ----------------------------------------
	typedef logic [31:0] addr_t;      // HADDR
	typedef logic [31:0] data_t;      // HWDATA / HRDATA
	typedef logic [1:0]  trans_t;     // HTRANS
	typedef logic [2:0]  size_t;      // HSIZE
	typedef logic [1:0]  slave_idx_t; // Data-phase owner

	localparam trans_t TRANS_IDLE   = 2'b00;
	localparam trans_t TRANS_BUSY   = 2'b01;
	localparam trans_t TRANS_NONSEQ = 2'b10;
	localparam trans_t TRANS_SEQ    = 2'b11;

	localparam size_t SIZE_BYTE = 3'b000;
	localparam size_t SIZE_HALF = 3'b001;
	localparam size_t SIZE_WORD = 3'b010;

	localparam slave_idx_t SLV_ISRAM = 2'd0;
	localparam slave_idx_t SLV_DSRAM = 2'd1;
	localparam slave_idx_t SLV_GPIO  = 2'd2;
	localparam slave_idx_t SLV_NONE  = 2'd3; // Unmapped or no transfer

	// ----------------------------------------
	// Address map, HADDR[31:28]
	// ----------------------------------------
	localparam logic [3:0] REGION_ISRAM = 4'h0;
	localparam logic [3:0] REGION_DSRAM = 4'h2;
	localparam logic [3:0] REGION_GPIO  = 4'h4;

	// GPIO register offsets, HADDR[7:0]
	localparam logic [7:0] GPIO_DATA    = 8'h00; // Synced inputs, RO
	localparam logic [7:0] GPIO_DOUT    = 8'h04;
	localparam logic [7:0] GPIO_OUTEN   = 8'h08;
	localparam logic [7:0] GPIO_INTEN   = 8'h0C;
	localparam logic [7:0] GPIO_INTSTAT = 8'h10; // W1C

endpackage

// File: design/ahb_slave_if.sv
`timescale 1ns/100ps

interface ahb_slave_if import ahb_pkg::*; ();

	// Address phase, from the decoder
	logic   sel;
	addr_t  addr;
	trans_t trans;
	logic   write;
	size_t  size;
	data_t  wdata;    // Valid in the data phase

	logic   ready;    // Muxed HREADY

	// Slave response
	logic   readyout;
	data_t  rdata;
	logic   resp;

	modport req (
		output sel, addr, trans, write, size, wdata,
		input  ready
	);

	modport rsp (
		output ready,
		input  readyout, rdata, resp
	);

	modport slave (
		input  sel, addr, trans, write, size, wdata, ready,
		output readyout, rdata, resp
	);

endinterface

// File: design/ahb_addr_decode.sv
`timescale 1ns/100ps

module ahb_addr_decode import ahb_pkg::*; (
	input  logic       hclk_i,
	input  logic       arst_n_i,
	input  addr_t      haddr_i,
	input  trans_t     htrans_i,
	input  logic       hwrite_i,
	input  size_t      hsize_i,
	input  data_t      hwdata_i,
	ahb_slave_if.req   isram_o,
	ahb_slave_if.req   dsram_o,
	ahb_slave_if.req   gpio_o,
	output slave_idx_t owner_o,
	output logic       err_pend_o
);

	logic       active;   // NONSEQ or SEQ
	slave_idx_t region;
	slave_idx_t owner_q;
	logic       err_q;

	always_comb begin
		case (htrans_i)
			TRANS_NONSEQ, TRANS_SEQ: active = 1'b1;
			TRANS_IDLE, TRANS_BUSY:  active = 1'b0;
			default:                 active = 1'b0;
		endcase

		case (haddr_i[31:28])
			REGION_ISRAM: region = SLV_ISRAM;
			REGION_DSRAM: region = SLV_DSRAM;
			REGION_GPIO:  region = SLV_GPIO;
			default:      region = SLV_NONE;
		endcase
	end

	assign isram_o.sel = active && (region == SLV_ISRAM);
	assign dsram_o.sel = active && (region == SLV_DSRAM);
	assign gpio_o.sel  = active && (region == SLV_GPIO);

	// Same request broadcast to every slave
	assign {isram_o.addr, isram_o.trans, isram_o.write, isram_o.size, isram_o.wdata} =
		{haddr_i, htrans_i, hwrite_i, hsize_i, hwdata_i};
	assign {dsram_o.addr, dsram_o.trans, dsram_o.write, dsram_o.size, dsram_o.wdata} =
		{haddr_i, htrans_i, hwrite_i, hsize_i, hwdata_i};
	assign {gpio_o.addr, gpio_o.trans, gpio_o.write, gpio_o.size, gpio_o.wdata} =
		{haddr_i, htrans_i, hwrite_i, hsize_i, hwdata_i};

	// Data-phase owner, advances only when the bus is ready
	always_ff @(posedge hclk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			owner_q <= SLV_NONE;
			err_q   <= 1'b0;
		end else if (isram_o.ready) begin
			owner_q <= active ? region : SLV_NONE;
			err_q   <= active && (region == SLV_NONE); // Unmapped hit
		end
	end

	assign owner_o    = owner_q;
	assign err_pend_o = err_q;

	// Stalled address phase must stay put, the held owner depends on it
	a_req_hold: assert property (@(posedge hclk_i) disable iff (!arst_n_i)
		!isram_o.ready |=> $stable(haddr_i) && $stable(htrans_i));

endmodule

// File: design/ahb_sram.sv
`timescale 1ns/100ps

module ahb_sram import ahb_pkg::*; #(
	parameter int AW = 10
) (
	input  logic       hclk_i,
	input  logic       arst_n_i,
	ahb_slave_if.slave bus_i
);

	localparam int DEPTH = 2 ** (AW - 2);

	data_t          mem [DEPTH];
	logic           accept;
	logic           sel_q;
	logic           write_q;
	logic  [AW-1:0] addr_q;  // Upper region bits alias
	size_t          size_q;
	logic  [3:0]    byte_en;

	assign accept = bus_i.sel && bus_i.ready &&
		(bus_i.trans == TRANS_NONSEQ || bus_i.trans == TRANS_SEQ);

	// ----------------------------------------
	// Address phase capture
	// ----------------------------------------
	always_ff @(posedge hclk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			sel_q   <= 1'b0;
			write_q <= 1'b0;
		end else if (bus_i.ready) begin
			sel_q   <= accept;
			write_q <= accept && bus_i.write;
		end
	end

	always_ff @(posedge hclk_i) begin
		if (accept) begin
			addr_q <= bus_i.addr[AW-1:0];
			size_q <= bus_i.size;
		end
	end

	// ----------------------------------------
	// Data phase
	// ----------------------------------------
	always_comb begin
		case (size_q)
			SIZE_BYTE: byte_en = 4'b0001 << addr_q[1:0];
			SIZE_HALF: byte_en = addr_q[1] ? 4'b1100 : 4'b0011;
			SIZE_WORD: byte_en = 4'b1111;
			default:   byte_en = 4'b0000;  // Oversize, no write
		endcase
	end

	// Lane merge lands on the edge that ends the data phase
	always_ff @(posedge hclk_i) begin
		if (sel_q && write_q) begin
			for (int i = 0; i < 4; i++) begin
				if (byte_en[i])
					mem[addr_q[AW-1:2]][8*i +: 8] <= bus_i.wdata[8*i +: 8];
			end
		end
	end

	assign bus_i.rdata    = mem[addr_q[AW-1:2]];  // Whole word, lanes picked by master
	assign bus_i.readyout = 1'b1;                  // Zero wait
	assign bus_i.resp     = 1'b0;                  // Always OKAY

	// Master must not issue oversize or misaligned halfword accesses
	a_size_align: assert property (@(posedge hclk_i) disable iff (!arst_n_i)
		accept |-> (bus_i.size <= SIZE_WORD) &&
			(bus_i.size != SIZE_HALF || !bus_i.addr[0]));

endmodule

// File: design/ahb_gpio.sv
`timescale 1ns/100ps

module ahb_gpio import ahb_pkg::*; #(
	parameter int GPIO_WIDTH = 16
) (
	input  logic                  hclk_i,
	input  logic                  arst_n_i,
	ahb_slave_if.slave            bus_i,
	input  logic [GPIO_WIDTH-1:0] gpio_in_i,
	output logic [GPIO_WIDTH-1:0] gpio_out_o,
	output logic [GPIO_WIDTH-1:0] gpio_oe_o,
	output logic [GPIO_WIDTH-1:0] gpio_int_o,
	output logic                  gpio_comb_int_o
);

	logic                  accept;
	logic                  sel_q;
	logic                  write_q;
	logic                  word_q;
	logic [7:0]            offs_q;    // Register offset
	logic                  wr_en;
	logic [GPIO_WIDTH-1:0] wr_data;
	logic [GPIO_WIDTH-1:0] dout_q;
	logic [GPIO_WIDTH-1:0] outen_q;
	logic [GPIO_WIDTH-1:0] inten_q;
	logic [GPIO_WIDTH-1:0] intstat_q;
	logic [GPIO_WIDTH-1:0] sync1_q;
	logic [GPIO_WIDTH-1:0] sync2_q;   // Visible in GPIO_DATA
	logic [GPIO_WIDTH-1:0] prev_q;
	logic [GPIO_WIDTH-1:0] rise;
	logic [GPIO_WIDTH-1:0] clr;

	assign accept = bus_i.sel && bus_i.ready &&
		(bus_i.trans == TRANS_NONSEQ || bus_i.trans == TRANS_SEQ);

	always_ff @(posedge hclk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			sel_q   <= 1'b0;
			write_q <= 1'b0;
			word_q  <= 1'b0;
		end else if (bus_i.ready) begin
			sel_q   <= accept;
			write_q <= accept && bus_i.write;
			word_q  <= accept && (bus_i.size == SIZE_WORD);
		end
	end

	always_ff @(posedge hclk_i) begin
		if (accept)
			offs_q <= bus_i.addr[7:0];
	end

	assign wr_en   = sel_q && write_q && word_q;
	assign wr_data = bus_i.wdata[GPIO_WIDTH-1:0];
	assign rise    = sync2_q & ~prev_q;
	assign clr     = (wr_en && offs_q == GPIO_INTSTAT) ? wr_data : '0;

	// ----------------------------------------
	// Registers and input synchronizer
	// ----------------------------------------
	always_ff @(posedge hclk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			dout_q    <= '0;
			outen_q   <= '0;
			inten_q   <= '0;
			intstat_q <= '0;
			sync1_q   <= '0;
			sync2_q   <= '0;
			prev_q    <= '0;
		end else begin
			sync1_q   <= gpio_in_i;
			sync2_q   <= sync1_q;
			prev_q    <= sync2_q;
			intstat_q <= (intstat_q & ~clr) | (rise & inten_q); // New edge wins
			if (wr_en && offs_q == GPIO_DOUT)  dout_q  <= wr_data;
			if (wr_en && offs_q == GPIO_OUTEN) outen_q <= wr_data;
			if (wr_en && offs_q == GPIO_INTEN) inten_q <= wr_data;
		end
	end

	always_comb begin
		bus_i.rdata = '0;
		case (offs_q)
			GPIO_DATA:    bus_i.rdata[GPIO_WIDTH-1:0] = sync2_q;
			GPIO_DOUT:    bus_i.rdata[GPIO_WIDTH-1:0] = dout_q;
			GPIO_OUTEN:   bus_i.rdata[GPIO_WIDTH-1:0] = outen_q;
			GPIO_INTEN:   bus_i.rdata[GPIO_WIDTH-1:0] = inten_q;
			GPIO_INTSTAT: bus_i.rdata[GPIO_WIDTH-1:0] = intstat_q;
			default:      bus_i.rdata = '0;  // Unknown offset
		endcase
	end

	assign bus_i.readyout  = 1'b1;
	assign bus_i.resp      = 1'b0;
	assign gpio_out_o      = dout_q;
	assign gpio_oe_o       = outen_q;
	assign gpio_int_o      = intstat_q;
	assign gpio_comb_int_o = |intstat_q;

	a_word_only: assert property (@(posedge hclk_i) disable iff (!arst_n_i)
		accept |-> bus_i.size == SIZE_WORD);

endmodule

// File: design/ahb_resp_mux.sv
`timescale 1ns/100ps

module ahb_resp_mux import ahb_pkg::*; (
	input  logic       hclk_i,
	input  logic       arst_n_i,
	input  slave_idx_t owner_i,
	input  logic       err_pend_i,
	ahb_slave_if.rsp   isram_i,
	ahb_slave_if.rsp   dsram_i,
	ahb_slave_if.rsp   gpio_i,
	output data_t      hrdata_o,
	output logic       hready_o,
	output logic       hresp_o
);

	typedef enum logic {
		ERR_IDLE,
		ERR_SECOND
	} err_state_t;

	err_state_t err_state;

	// ----------------------------------------
	// Default slave, two-cycle ERROR
	// ----------------------------------------
	always_ff @(posedge hclk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			err_state <= ERR_IDLE;
		end else begin
			case (err_state)
				ERR_IDLE:   if (err_pend_i) err_state <= ERR_SECOND;
				ERR_SECOND: err_state <= ERR_IDLE;
				default:    err_state <= ERR_IDLE;
			endcase
		end
	end

	always_comb begin
		hrdata_o = '0;
		hready_o = 1'b1;  // Idle bus is ready and OKAY
		hresp_o  = 1'b0;
		if (err_pend_i) begin
			hready_o = (err_state == ERR_SECOND);
			hresp_o  = 1'b1;
		end else begin
			case (owner_i)
				SLV_ISRAM: begin
					hrdata_o = isram_i.rdata;
					hready_o = isram_i.readyout;
					hresp_o  = isram_i.resp;
				end
				SLV_DSRAM: begin
					hrdata_o = dsram_i.rdata;
					hready_o = dsram_i.readyout;
					hresp_o  = dsram_i.resp;
				end
				SLV_GPIO: begin
					hrdata_o = gpio_i.rdata;
					hready_o = gpio_i.readyout;
					hresp_o  = gpio_i.resp;
				end
				default: ;
			endcase
		end
	end

	// HREADY fed back to every slave
	assign isram_i.ready = hready_o;
	assign dsram_i.ready = hready_o;
	assign gpio_i.ready  = hready_o;

	a_err_two_cycle: assert property (@(posedge hclk_i) disable iff (!arst_n_i)
		(hresp_o && !hready_o) |=> (hresp_o && hready_o));

endmodule

// File: design/soc_top.sv
`timescale 1ns/100ps

module soc_top import ahb_pkg::*; #(
	parameter int AW         = 10,
	parameter int GPIO_WIDTH = 16
) (
	input  logic                  hclk_i,
	input  logic                  arst_n_i,

	// AHB-Lite master side
	input  addr_t                 haddr_i,
	input  trans_t                htrans_i,
	input  logic                  hwrite_i,
	input  size_t                 hsize_i,
	input  data_t                 hwdata_i,
	output data_t                 hrdata_o,
	output logic                  hready_o,
	output logic                  hresp_o,

	// GPIO pins
	input  logic [GPIO_WIDTH-1:0] gpio_in_i,
	output logic [GPIO_WIDTH-1:0] gpio_out_o,
	output logic [GPIO_WIDTH-1:0] gpio_oe_o,
	output logic [GPIO_WIDTH-1:0] gpio_int_o,
	output logic                  gpio_comb_int_o
);

	slave_idx_t owner;     // Data-phase owner
	logic       err_pend;  // Unmapped data phase

	ahb_slave_if isram_bus ();
	ahb_slave_if dsram_bus ();
	ahb_slave_if gpio_bus ();

	// ----------------------------------------
	// Address phase
	// ----------------------------------------
	ahb_addr_decode u_decode (
		.hclk_i     (hclk_i),
		.arst_n_i   (arst_n_i),
		.haddr_i    (haddr_i),
		.htrans_i   (htrans_i),
		.hwrite_i   (hwrite_i),
		.hsize_i    (hsize_i),
		.hwdata_i   (hwdata_i),
		.isram_o    (isram_bus),
		.dsram_o    (dsram_bus),
		.gpio_o     (gpio_bus),
		.owner_o    (owner),
		.err_pend_o (err_pend)
	);

	// ----------------------------------------
	// Slaves
	// ----------------------------------------
	ahb_sram #(.AW(AW)) u_isram (
		.hclk_i   (hclk_i),
		.arst_n_i (arst_n_i),
		.bus_i    (isram_bus)
	);

	ahb_sram #(.AW(AW)) u_dsram (
		.hclk_i   (hclk_i),
		.arst_n_i (arst_n_i),
		.bus_i    (dsram_bus)
	);

	ahb_gpio #(.GPIO_WIDTH(GPIO_WIDTH)) u_gpio (
		.hclk_i          (hclk_i),
		.arst_n_i        (arst_n_i),
		.bus_i           (gpio_bus),
		.gpio_in_i       (gpio_in_i),
		.gpio_out_o      (gpio_out_o),
		.gpio_oe_o       (gpio_oe_o),
		.gpio_int_o      (gpio_int_o),
		.gpio_comb_int_o (gpio_comb_int_o)
	);

	// Data phase
	ahb_resp_mux u_resp (
		.hclk_i     (hclk_i),
		.arst_n_i   (arst_n_i),
		.owner_i    (owner),
		.err_pend_i (err_pend),
		.isram_i    (isram_bus),
		.dsram_i    (dsram_bus),
		.gpio_i     (gpio_bus),
		.hrdata_o   (hrdata_o),
		.hready_o   (hready_o),
		.hresp_o    (hresp_o)
	);

endmodule

// File: verif/tb_top.sv
`timescale 1ns/100ps

module tb_top import ahb_pkg::*; ();

	localparam int AW              = 10;
	localparam int GPIO_WIDTH      = 16;
	localparam int N_WORD          = 24;  // Offsets, each written in both SRAMs
	localparam int N_LANE          = 12;
	localparam int N_PIPE          = 16;
	localparam int N_ERR           = 6;
	localparam int N_GPIO          = 6;
	localparam int N_IRQ           = 5;
	localparam int TOTAL_XFERS     = 4*N_WORD + 8*N_LANE + 6*N_PIPE + 4*N_ERR
		+ 10*N_GPIO + 20*N_IRQ + 20;
	localparam int WATCHDOG_CYCLES = TOTAL_XFERS*10 + 1000;

	logic                  hclk;
	logic                  arst_n;
	addr_t                 haddr;
	trans_t                htrans;
	logic                  hwrite;
	size_t                 hsize;
	data_t                 hwdata;
	data_t                 hrdata;
	logic                  hready;
	logic                  hresp;
	logic [GPIO_WIDTH-1:0] gpio_in;
	logic [GPIO_WIDTH-1:0] gpio_out;
	logic [GPIO_WIDTH-1:0] gpio_oe;
	logic [GPIO_WIDTH-1:0] gpio_int;
	logic                  gpio_comb_int;

	// Transfer now in its data phase
	logic                  p_err;
	logic                  p_chk;
	addr_t                 p_addr;
	data_t                 p_wdata;
	data_t                 p_exp;

	data_t                 sram_model [int];  // Key is region bit and word index
	logic [GPIO_WIDTH-1:0] m_dout;
	logic [GPIO_WIDTH-1:0] m_outen;
	logic [GPIO_WIDTH-1:0] m_inten;
	logic [GPIO_WIDTH-1:0] m_intstat;
	logic [31:0]           rng;
	int                    errors;
	int                    pass_cnt;
	int                    fail_cnt;

	soc_top #(.AW(AW), .GPIO_WIDTH(GPIO_WIDTH)) dut (
		.hclk_i          (hclk),
		.arst_n_i        (arst_n),
		.haddr_i         (haddr),
		.htrans_i        (htrans),
		.hwrite_i        (hwrite),
		.hsize_i         (hsize),
		.hwdata_i        (hwdata),
		.hrdata_o        (hrdata),
		.hready_o        (hready),
		.hresp_o         (hresp),
		.gpio_in_i       (gpio_in),
		.gpio_out_o      (gpio_out),
		.gpio_oe_o       (gpio_oe),
		.gpio_int_o      (gpio_int),
		.gpio_comb_int_o (gpio_comb_int)
	);

	initial begin
		hclk = 1'b0;
		forever #4 hclk = ~hclk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge hclk);
		$display("watchdog timeout after %0d cycles, the bus stalled or a test hung",
			WATCHDOG_CYCLES);
		$display("tests failed");
		$finish;
	end

	// ----------------------------------------
	// Helpers
	// ----------------------------------------
	function automatic logic [31:0] rand32();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// Bits above AW alias, so they are left out of the key
	function automatic int sram_key(addr_t a);
		return int'({a[31:28] == REGION_DSRAM, a[AW-1:2]});
	endfunction

	function automatic addr_t sram_addr(logic dsram, logic [AW-1:0] offs);
		logic [31:0] r;
		r = rand32();
		return {dsram ? REGION_DSRAM : REGION_ISRAM, r[27:AW], offs};  // Random alias
	endfunction

	function automatic data_t merge_lanes(data_t old, data_t wd, size_t s, logic [1:0] lo);
		data_t res;
		logic  hit;
		res = old;
		for (int b = 0; b < 4; b++) begin
			case (s)
				SIZE_BYTE: hit = (b[1:0] == lo);
				SIZE_HALF: hit = (b[1] == lo[1]);
				default:   hit = 1'b1;
			endcase
			if (hit)
				res[8*b +: 8] = wd[8*b +: 8];
		end
		return res;
	endfunction

	// One address phase, entered 1 ns after a rising edge
	task automatic bus_step(input logic act, input addr_t a, input logic wr, input size_t s,
		input data_t wd, input logic chk, input data_t exp);
		int   waits;
		logic err_now;
		waits   = 0;
		err_now = act && !(a[31:28] inside {REGION_ISRAM, REGION_DSRAM, REGION_GPIO});
		haddr   = a;
		htrans  = act ? TRANS_NONSEQ : TRANS_IDLE;
		hwrite  = wr;
		hsize   = s;
		hwdata  = p_wdata;  // Previous transfer's write data
		while (hready !== 1'b1) begin
			assert (p_err && hresp === 1'b1 && waits == 0)
			else begin
				$display("MISMATCH at %0t: wait state on %h, hresp=%b waits=%0d",
					$time, p_addr, hresp, waits);
				errors++;
			end
			waits++;
			@(posedge hclk);
			#1;
		end
		assert (hresp === p_err && waits == (p_err ? 1 : 0))
		else begin
			$display("MISMATCH at %0t: %h ended with hresp=%b after %0d waits, error expected %b",
				$time, p_addr, hresp, waits, p_err);
			errors++;
		end
		if (p_chk) begin
			assert (hrdata === p_exp)
			else begin
				$display("MISMATCH at %0t: read %h returned %h, expected %h",
					$time, p_addr, hrdata, p_exp);
				errors++;
			end
		end
		@(posedge hclk);
		#1;
		p_err   = err_now;
		p_chk   = chk;
		p_addr  = a;
		p_wdata = wd;
		p_exp   = exp;
	endtask

	task automatic idle_cycles(int n);
		repeat (n) bus_step(1'b0, '0, 1'b0, SIZE_WORD, '0, 1'b0, '0);
	endtask

	// IDLE transfers aimed at a live address with write set
	task automatic idle_writes(addr_t a, int n);
		repeat (n) bus_step(1'b0, a, 1'b1, SIZE_WORD, rand32(), 1'b0, '0);
	endtask

	task automatic sram_write(addr_t a, size_t s, data_t d);
		int k;
		k = sram_key(a);
		sram_model[k] = merge_lanes(sram_model.exists(k) ? sram_model[k] : '0, d, s, a[1:0]);
		bus_step(1'b1, a, 1'b1, s, d, 1'b0, '0);
	endtask

	task automatic sram_read(addr_t a);
		bus_step(1'b1, a, 1'b0, SIZE_WORD, '0, 1'b1, sram_model[sram_key(a)]);
	endtask

	task automatic gpio_write(logic [7:0] off, data_t d);
		case (off)
			GPIO_DOUT:    m_dout    = d[GPIO_WIDTH-1:0];
			GPIO_OUTEN:   m_outen   = d[GPIO_WIDTH-1:0];
			GPIO_INTEN:   m_inten   = d[GPIO_WIDTH-1:0];
			GPIO_INTSTAT: m_intstat = m_intstat & ~d[GPIO_WIDTH-1:0];  // W1C
			default: ;
		endcase
		bus_step(1'b1, {REGION_GPIO, 20'h0, off}, 1'b1, SIZE_WORD, d, 1'b0, '0);
	endtask

	task automatic gpio_read(logic [7:0] off, logic [GPIO_WIDTH-1:0] v);
		bus_step(1'b1, {REGION_GPIO, 20'h0, off}, 1'b0, SIZE_WORD, '0, 1'b1,
			{{(32 - GPIO_WIDTH){1'b0}}, v});
	endtask

	task automatic check_pins();
		assert (gpio_out === m_dout && gpio_oe === m_outen && gpio_int === m_intstat
			&& gpio_comb_int === |m_intstat)
		else begin
			$display("MISMATCH at %0t: pins out=%h oe=%h int=%h comb=%b, expected %h %h %h",
				$time, gpio_out, gpio_oe, gpio_int, gpio_comb_int, m_dout, m_outen, m_intstat);
			errors++;
		end
	endtask

	task automatic report_test(string name, int errs_before);
		if (errors == errs_before) begin
			pass_cnt++;
			$display("test %s: ok", name);
		end else begin
			fail_cnt++;
			$display("test %s: %0d errors", name, errors - errs_before);
		end
	endtask

	// ----------------------------------------
	// Test sequence
	// ----------------------------------------
	initial begin
		logic [31:0]           r;
		addr_t                 a;
		addr_t                 known;
		logic [AW-1:0]         offs [N_WORD];
		logic                  dsel;
		logic [3:0]            nib;
		logic [1:0]            lo;
		size_t                 s;
		int                    eb;
		arst_n  = 1'b0;
		haddr   = '0;
		htrans  = TRANS_IDLE;
		hwrite  = 1'b0;
		hsize   = SIZE_WORD;
		hwdata  = '0;
		gpio_in = '0;
		p_err   = 1'b0;
		p_chk   = 1'b0;
		p_addr  = '0;
		p_wdata = '0;
		p_exp   = '0;
		m_dout  = '0;
		m_outen = '0;
		m_inten = '0;
		m_intstat = '0;
		rng      = 32'd73559;
		errors   = 0;
		pass_cnt = 0;
		fail_cnt = 0;

		repeat (5) @(posedge hclk);
		#1;
		eb = errors;
		assert (hready === 1'b1 && hresp === 1'b0)
		else begin
			$display("MISMATCH at %0t: after reset hready=%b hresp=%b", $time, hready, hresp);
			errors++;
		end
		check_pins();
		arst_n = 1'b1;
		report_test("reset", eb);

		eb = errors;
		for (int i = 0; i < N_WORD; i++) begin
			r = rand32();
			offs[i] = {r[AW-1:2], 2'b00};
			sram_write(sram_addr(1'b0, offs[i]), SIZE_WORD, rand32());
			sram_write(sram_addr(1'b1, offs[i]), SIZE_WORD, rand32());  // Same offset, other SRAM
		end
		for (int i = 0; i < N_WORD; i++) begin
			sram_read(sram_addr(1'b0, offs[i]));
			sram_read(sram_addr(1'b1, offs[i]));
		end
		idle_cycles(1);
		report_test("sram_words", eb);

		eb = errors;
		for (int i = 0; i < N_LANE; i++) begin
			r = rand32();
			dsel = r[31];
			a = sram_addr(dsel, {r[AW-1:2], 2'b00});
			sram_write(a, SIZE_WORD, rand32());
			repeat (4) begin
				r = rand32();
				s = r[0] ? SIZE_HALF : SIZE_BYTE;
				lo = r[0] ? {r[1], 1'b0} : r[2:1];
				sram_write({a[31:2], lo}, s, rand32());
			end
			sram_read(sram_addr(dsel, a[AW-1:0]));
		end
		idle_cycles(1);
		report_test("sram_lanes", eb);

		eb = errors;
		known = '0;
		for (int i = 0; i < N_PIPE; i++) begin
			r = rand32();
			a = sram_addr(r[31], {r[AW-1:2], 2'b00});
			sram_write(a, SIZE_WORD, rand32());
			sram_read(a);  // Overlaps the write's data phase
			idle_writes(a, int'(r[13:12]));
			sram_read(a);
			known = a;
		end
		idle_cycles(1);
		report_test("pipeline", eb);

		eb = errors;
		for (int i = 0; i < N_ERR; i++) begin
			r = rand32();
			nib = r[31:28];
			if (nib inside {REGION_ISRAM, REGION_DSRAM, REGION_GPIO})
				nib = nib + 4'd1;
			bus_step(1'b1, {nib, r[27:0]}, r[0], SIZE_WORD, rand32(), 1'b0, '0);
			sram_read(known);
		end
		idle_cycles(1);
		report_test("unmapped", eb);

		eb = errors;
		for (int i = 0; i < N_GPIO; i++) begin
			gpio_write(GPIO_DOUT, rand32());
			gpio_write(GPIO_OUTEN, rand32());
			gpio_read(GPIO_DOUT, m_dout);
			gpio_read(GPIO_OUTEN, m_outen);
			idle_cycles(1);
			check_pins();
			r = rand32();
			gpio_in = r[GPIO_WIDTH-1:0];
			idle_cycles(2);  // Two-flop synchronizer
			gpio_read(GPIO_DATA, gpio_in);
		end
		gpio_read(8'h14, '0);
		idle_cycles(1);
		report_test("gpio_out_in", eb);

		eb = errors;
		for (int i = 0; i < N_IRQ; i++) begin
			gpio_in = '0;
			idle_cycles(4);  // Falling edges only
			gpio_write(GPIO_INTEN, rand32());
			gpio_write(GPIO_INTSTAT, 32'hFFFF_FFFF);
			idle_cycles(1);
			r = rand32();
			gpio_in = r[GPIO_WIDTH-1:0];
			m_intstat = m_intstat | (gpio_in & m_inten);
			idle_cycles(3);  // Sync plus edge detect
			check_pins();
			gpio_read(GPIO_INTSTAT, m_intstat);
			gpio_write(GPIO_INTSTAT, rand32());
			gpio_read(GPIO_INTSTAT, m_intstat);
			idle_cycles(1);
			check_pins();
		end
		report_test("gpio_irq", eb);

		$display("tests run %0d: %0d ok, %0d with errors", pass_cnt + fail_cnt, pass_cnt,
			fail_cnt);
		if (fail_cnt == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// File: build.f
design/ahb_pkg.sv
design/ahb_slave_if.sv
design/ahb_addr_decode.sv
design/ahb_sram.sv
design/ahb_gpio.sv
design/ahb_resp_mux.sv
design/soc_top.sv
verif/tb_top.sv

// File: run.sh
#!/bin/sh
# Compile with Verilator, run, and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tb_top -f build.f -o Vtb_top \
	&& ./obj_dir/Vtb_top > sim.log 2>&1 \
	|| echo "build or simulation did not complete"

cat sim.log 2>/dev/null
grep -q "^all tests passed$" sim.log 2>/dev/null && echo "PASS" && exit 0 \
	|| { echo "FAIL"; exit 1; }
